//--- verilog.f
rtl/alu_pkg.sv
rtl/wb_map_pkg.sv
rtl/fast_adder_16.sv
rtl/alu_exec.sv
rtl/alu_regs.sv
rtl/alu_ctrl.sv
rtl/alu_wb_top.sv
tests/tb_alu_wb.sv

//--- Makefile
SIM := obj_dir/Vtb_alu_wb

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert --timescale 1ns/1ps --top-module tb_alu_wb -f verilog.f

run: build
	./$(SIM) > sim.log 2>&1; status=$$?; cat sim.log; exit $$status
	@if grep -q "Test failures found" sim.log; then echo "simulation reported errors"; exit 1; fi
	@echo "simulation finished without errors"

lint:
	verilator --lint-only -Wall --timing --timescale 1ns/1ps --top-module tb_alu_wb -f verilog.f

clean:
	rm -rf obj_dir sim.log

//--- tests/tb_alu_wb.sv
// Testbench for the Wishbone ALU coprocessor; run tb_alu_wb as top with the DUT from verilog.f.
`default_nettype none

module tb_alu_wb;

    timeunit 1ns;
    timeprecision 1ps;

    import alu_pkg::*;
    import wb_map_pkg::*;

    // about 12 cycles per operation, 230 operations, plus reset and slack.
    localparam int CYCLE_LIMIT = 4000;

    logic              clk;
    logic              rst;
    logic              cyc;
    logic              stb;
    logic              we;
    logic [3:0]        adr;
    logic [DATA_W-1:0] dat_w;
    logic [DATA_W-1:0] dat_r;
    logic              ack;
    logic [DATA_W-1:0] exp_rd;
    logic              cmd_ack;
    int                err_count   = 0;
    int                cycle_count = 0;
    int                seed        = 19;

    alu_wb_top u_dut (
        .clk   (clk),
        .rst   (rst),
        .cyc   (cyc),
        .stb   (stb),
        .we    (we),
        .adr   (adr),
        .dat_w (dat_w),
        .dat_r (dat_r),
        .ack   (ack)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= CYCLE_LIMIT) begin
            $display("timeout: tests did not finish within %0d cycles", CYCLE_LIMIT);
            $display("Test failures found");
            $finish;
        end
    end

    assign cmd_ack = ack && we && (adr[3:2] == REG_CMD);

    a_read_data: assert property (@(posedge clk) disable iff (rst)
        (ack && !we) |-> (dat_r == exp_rd))
        else begin
            err_count++;
            $display("ERR dat_r adr %h expected %h actual %h",
                     $sampled(adr), $sampled(exp_rd), $sampled(dat_r));
        end

    a_ack_after_req: assert property (@(posedge clk) disable iff (rst)
        ack |-> $past(cyc && stb))
        else begin
            err_count++;
            $display("ack was raised without a bus request in the cycle before");
        end

    // busy lasts two cycles past the command ack, so the next command waits.
    a_cmd_spacing: assert property (@(posedge clk) disable iff (rst)
        cmd_ack |=> !cmd_ack ##1 !cmd_ack ##1 !cmd_ack)
        else begin
            err_count++;
            $display("command write was acked while the previous command was busy");
        end

    function automatic logic [35:0] ref_model(input alu_op_e op, input logic [31:0] a,
                                              input logic [31:0] b);
        logic [32:0] wide;
        logic [32:0] diff;
        logic [31:0] r;
        logic [3:0]  f;
        logic        sub_v;
        f     = '0;
        diff  = {1'b0, a} + {1'b0, ~b} + 33'd1;
        sub_v = (a[31] != b[31]) && (diff[31] != a[31]);
        case (op)
            OP_ADD: begin
                wide      = {1'b0, a} + {1'b0, b};
                r         = wide[31:0];
                f[FLAG_C] = wide[32];
                f[FLAG_V] = (a[31] == b[31]) && (r[31] != a[31]);
            end
            OP_SUB: begin
                r         = diff[31:0];
                f[FLAG_C] = diff[32]; // set when no borrow.
                f[FLAG_V] = sub_v;
            end
            OP_AND: r = a & b;
            OP_OR:  r = a | b;
            OP_XOR: r = a ^ b;
            OP_SLT: begin
                r         = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                f[FLAG_C] = diff[32];
                f[FLAG_V] = sub_v;
            end
            OP_SLL: r = a << b[4:0];
            OP_SRL: r = a >> b[4:0];
            default: r = '0;
        endcase
        f[FLAG_Z] = (r == '0);
        f[FLAG_N] = r[31];
        return {f, r};
    endfunction

    function automatic logic [31:0] status_word(input logic busy_v, input logic [3:0] f);
        logic [31:0] st;
        st            = '0;
        st[3:0]       = f;
        st[STAT_BUSY] = busy_v;
        return st;
    endfunction

    // starts 1 ns after an edge, holds the request through the ack cycle.
    task automatic bus_cycle(input logic we_v, input logic [1:0] word, input logic [31:0] wdata,
                             output int waits);
        cyc   = 1'b1;
        stb   = 1'b1;
        we    = we_v;
        adr   = {word, 2'b00};
        dat_w = wdata;
        waits = 0;
        do begin
            @(posedge clk);
            #1;
            waits++;
        end while (!ack);
        @(posedge clk);
        #1;
        cyc = 1'b0;
        stb = 1'b0;
        we  = 1'b0;
    endtask

    task automatic write_reg(input logic [1:0] word, input logic [31:0] data, output int waits);
        bus_cycle(1'b1, word, data, waits);
    endtask

    task automatic read_check(input logic [1:0] word, input logic [31:0] expected);
        int waits;
        exp_rd = expected;
        bus_cycle(1'b0, word, 32'd0, waits);
    endtask

    task automatic check_outcome(input logic [35:0] expected);
        read_check(REG_CMD, status_word(1'b1, expected[35:32])); // still in ST_DONE.
        read_check(REG_CMD, status_word(1'b0, expected[35:32]));
        read_check(REG_RESULT, expected[31:0]);
    endtask

    task automatic run_op(input logic [31:0] a, input logic [31:0] b, input alu_op_e op);
        int waits;
        write_reg(REG_OP_A, a, waits);
        write_reg(REG_OP_B, b, waits);
        write_reg(REG_CMD, {29'd0, op}, waits);
        check_outcome(ref_model(op, a, b));
    endtask

    initial begin
        int          waits;
        logic [31:0] ra;
        logic [31:0] rb;
        logic [31:0] rnd;
        rst    = 1'b1;
        cyc    = 1'b0;
        stb    = 1'b0;
        we     = 1'b0;
        adr    = 4'd0;
        dat_w  = '0;
        exp_rd = '0;
        repeat (16) @(posedge clk);
        #1;
        rst = 1'b0;
        assert (!ack) else begin
            err_count++;
            $display("ack was high after reset before any request");
        end
        read_check(REG_OP_A, 32'd0);
        read_check(REG_OP_B, 32'd0);
        read_check(REG_CMD, 32'd0);
        read_check(REG_RESULT, 32'd0);

        run_op(32'h0000_FFFF, 32'h0000_0001, OP_ADD); // carry into the upper block.
        run_op(32'hFFFF_FFFF, 32'h0000_0001, OP_ADD);
        run_op(32'h7FFF_FFFF, 32'h0000_0001, OP_ADD);
        run_op(32'h8000_0000, 32'h8000_0000, OP_ADD);
        run_op(32'h0001_0000, 32'h0000_0001, OP_SUB); // borrow across bit 15.
        run_op(32'h0000_0005, 32'h0000_0005, OP_SUB);
        run_op(32'h0000_0003, 32'h0000_0005, OP_SUB);
        run_op(32'h8000_0000, 32'h0000_0001, OP_SUB);

        run_op(32'hF0F0_A5A5, 32'h0FF0_5A5A, OP_AND);
        run_op(32'hF0F0_A5A5, 32'h0FF0_5A5A, OP_OR);
        run_op(32'hF0F0_A5A5, 32'h0FF0_5A5A, OP_XOR);
        run_op(32'hFFFF_0000, 32'h0000_FFFF, OP_AND);

        run_op(32'h8000_0001, 32'd0, OP_SLL);
        run_op(32'h8000_0001, 32'd1, OP_SLL);
        run_op(32'h8000_0001, 32'd31, OP_SLL);
        run_op(32'h8000_0001, 32'd0, OP_SRL);
        run_op(32'h8000_0001, 32'hFFFF_FFE1, OP_SRL); // only the low 5 bits count.
        run_op(32'h8000_0001, 32'd31, OP_SRL);
        run_op(32'hFFFF_FFFB, 32'h0000_0003, OP_SLT);
        run_op(32'h0000_0003, 32'hFFFF_FFFB, OP_SLT);

        // second command arrives right after the first one is acked.
        write_reg(REG_OP_A, 32'h1234_5678, waits);
        write_reg(REG_OP_B, 32'h0F0F_0F0F, waits);
        write_reg(REG_CMD, {29'd0, OP_ADD}, waits);
        write_reg(REG_CMD, {29'd0, OP_XOR}, waits);
        assert (waits > 1) else begin
            err_count++;
            $display("back-to-back command write was not stalled");
        end
        check_outcome(ref_model(OP_XOR, 32'h1234_5678, 32'h0F0F_0F0F));

        for (int i = 0; i < 200; i++) begin
            ra  = $random(seed);
            rb  = $random(seed);
            rnd = $random(seed);
            run_op(ra, rb, alu_op_e'(rnd[2:0]));
        end

        $display("checks done, errors: %0d", err_count);
        if (err_count == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- rtl/alu_wb_top.sv
// Top level of the Wishbone ALU coprocessor; connects control, register block and execution unit.
`default_nettype none

module alu_wb_top (
    input  wire                          clk,
    input  wire                          rst,
    input  wire                          cyc,
    input  wire                          stb,
    input  wire                          we,
    input  wire  [3:0]                   adr,
    input  wire  [alu_pkg::DATA_W-1:0]   dat_w,
    output logic [alu_pkg::DATA_W-1:0]   dat_r,
    output logic                         ack
);

    import alu_pkg::*;

    logic              wr_a;
    logic              wr_b;
    logic              wr_cmd;
    logic              capture;
    logic              busy;
    logic [DATA_W-1:0] op_a;
    logic [DATA_W-1:0] op_b;
    alu_op_e           op;
    logic [DATA_W-1:0] result;
    logic [3:0]        flags;

    alu_ctrl u_ctrl (
        .clk     (clk),
        .rst     (rst),
        .cyc     (cyc),
        .stb     (stb),
        .we      (we),
        .adr     (adr),
        .ack     (ack),
        .wr_a    (wr_a),
        .wr_b    (wr_b),
        .wr_cmd  (wr_cmd),
        .capture (capture),
        .busy    (busy)
    );

    alu_regs u_regs (
        .clk    (clk),
        .rst    (rst),
        .adr    (adr),
        .dat_w  (dat_w),
        .wr_a   (wr_a),
        .wr_b   (wr_b),
        .wr_cmd (wr_cmd),
        .busy   (busy),
        .result (result),
        .flags  (flags),
        .op_a   (op_a),
        .op_b   (op_b),
        .op     (op),
        .dat_r  (dat_r)
    );

    alu_exec u_exec (
        .clk     (clk),
        .rst     (rst),
        .op_a    (op_a),
        .op_b    (op_b),
        .op      (op),
        .capture (capture),
        .result  (result),
        .flags   (flags)
    );

endmodule

`default_nettype wire

//--- rtl/alu_ctrl.sv
// Control FSM: Wishbone ack, register write strobes and the execute sequence with command stall.
`default_nettype none

module alu_ctrl (
    input  wire        clk,
    input  wire        rst,
    input  wire        cyc,
    input  wire        stb,
    input  wire        we,
    input  wire  [3:0] adr,
    output logic       ack,
    output logic       wr_a,
    output logic       wr_b,
    output logic       wr_cmd,
    output logic       capture,
    output logic       busy
);

    import wb_map_pkg::*;

    ctrl_state_e state;
    logic        req;
    logic        cmd_req;
    logic        stall;

    assign req     = cyc && stb && !ack; // nothing new while acking.
    assign cmd_req = req && we && (adr[3:2] == REG_CMD);
    assign stall   = cmd_req && (state != ST_IDLE); // held until idle.

    // ack and strobes share one cycle.
    always_ff @(posedge clk) begin
        if (rst) begin
            ack    <= 1'b0;
            wr_a   <= 1'b0;
            wr_b   <= 1'b0;
            wr_cmd <= 1'b0;
        end else begin
            ack    <= req && !stall;
            wr_a   <= req && we && (adr[3:2] == REG_OP_A);
            wr_b   <= req && we && (adr[3:2] == REG_OP_B);
            wr_cmd <= cmd_req && !stall;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= ST_IDLE;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (wr_cmd) begin
                        state <= ST_EXEC;
                    end
                end
                ST_EXEC: state <= ST_DONE;  // result registered on this edge.
                ST_DONE: state <= ST_IDLE;
                default: state <= ST_IDLE;
            endcase
        end
    end

    assign capture = (state == ST_EXEC);
    assign busy    = (state != ST_IDLE);

    a_ack_in_cycle: assert property (@(posedge clk) disable iff (rst) ack |-> cyc && stb);

    a_ack_single: assert property (@(posedge clk) disable iff (rst) ack |=> !ack);

    // the FSM only takes a command in idle, a strobe elsewhere would be lost.
    a_cmd_in_idle: assert property (@(posedge clk) disable iff (rst)
        wr_cmd |-> state == ST_IDLE);

endmodule

`default_nettype wire

//--- rtl/alu_regs.sv
// Operand, command and result storage with the Wishbone read data mux.
`default_nettype none

module alu_regs (
    input  wire                          clk,
    input  wire                          rst,
    input  wire  [3:0]                   adr,
    input  wire  [alu_pkg::DATA_W-1:0]   dat_w,
    input  wire                          wr_a,
    input  wire                          wr_b,
    input  wire                          wr_cmd,
    input  wire                          busy,
    input  wire  [alu_pkg::DATA_W-1:0]   result,
    input  wire  [3:0]                   flags,
    output logic [alu_pkg::DATA_W-1:0]   op_a,
    output logic [alu_pkg::DATA_W-1:0]   op_b,
    output alu_pkg::alu_op_e             op,
    output logic [alu_pkg::DATA_W-1:0]   dat_r
);

    import alu_pkg::*;
    import wb_map_pkg::*;

    logic [DATA_W-1:0] status;

    always_ff @(posedge clk) begin
        if (rst) begin
            op_a <= '0;
            op_b <= '0;
            op   <= OP_ADD;
        end else begin
            if (wr_a) begin
                op_a <= dat_w;
            end
            if (wr_b) begin
                op_b <= dat_w;
            end
            if (wr_cmd) begin
                op <= alu_op_e'(dat_w[2:0]); // opcode sits in the low bits.
            end
        end
    end

    always_comb begin
        status            = '0;
        status[3:0]       = flags;
        status[STAT_BUSY] = busy;
    end

    // word select, byte offset ignored.
    always_comb begin
        case (adr[3:2])
            REG_OP_A:   dat_r = op_a;
            REG_OP_B:   dat_r = op_b;
            REG_CMD:    dat_r = status;
            REG_RESULT: dat_r = result;
            default:    dat_r = '0;
        endcase
    end

endmodule

`default_nettype wire

//--- rtl/alu_exec.sv
// 32-bit execution unit: two lookahead blocks, logic ops, shifts, flags and the result register.
`default_nettype none

module alu_exec (
    input  wire                          clk,
    input  wire                          rst,
    input  wire  [alu_pkg::DATA_W-1:0]   op_a,
    input  wire  [alu_pkg::DATA_W-1:0]   op_b,
    input  wire  alu_pkg::alu_op_e       op,
    input  wire                          capture,
    output logic [alu_pkg::DATA_W-1:0]   result,
    output logic [3:0]                   flags
);

    import alu_pkg::*;

    logic              sub_mode;
    logic              arith;
    logic [DATA_W-1:0] b_eff;
    logic [DATA_W-1:0] sum;
    logic              g_lo;
    logic              p_lo;
    logic              g_hi;
    logic              p_hi;
    logic              c_mid;
    logic              c_out;
    logic              ovf;
    logic [DATA_W-1:0] res_d;
    logic [3:0]        flags_d;

    assign sub_mode = (op == OP_SUB) || (op == OP_SLT); // a + ~b + 1.
    assign arith    = (op == OP_ADD) || sub_mode;
    assign b_eff    = sub_mode ? ~op_b : op_b;

    fast_adder_16 u_lo (
        .a    (op_a[15:0]),
        .b    (b_eff[15:0]),
        .cin  (sub_mode),
        .s    (sum[15:0]),
        .cout (),
        .gout (g_lo),
        .pout (p_lo)
    );

    // second lookahead level.
    assign c_mid = g_lo | (p_lo & sub_mode);
    assign c_out = g_hi | (p_hi & g_lo) | (p_hi & p_lo & sub_mode);

    fast_adder_16 u_hi (
        .a    (op_a[31:16]),
        .b    (b_eff[31:16]),
        .cin  (c_mid),
        .s    (sum[31:16]),
        .cout (),
        .gout (g_hi),
        .pout (p_hi)
    );

    assign ovf = (op_a[DATA_W-1] == b_eff[DATA_W-1]) && (sum[DATA_W-1] != op_a[DATA_W-1]);

    always_comb begin
        case (op)
            OP_ADD, OP_SUB: res_d = sum;
            OP_AND:         res_d = op_a & op_b;
            OP_OR:          res_d = op_a | op_b;
            OP_XOR:         res_d = op_a ^ op_b;
            OP_SLT:         res_d = {{(DATA_W-1){1'b0}}, sum[DATA_W-1] ^ ovf};
            OP_SLL:         res_d = op_a << op_b[4:0];
            OP_SRL:         res_d = op_a >> op_b[4:0];
            default:        res_d = '0;
        endcase
    end

    always_comb begin
        flags_d         = '0;
        flags_d[FLAG_Z] = (res_d == '0);
        flags_d[FLAG_N] = res_d[DATA_W-1];
        flags_d[FLAG_C] = arith & c_out; // arithmetic ops only.
        flags_d[FLAG_V] = arith & ovf;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            result <= '0;
            flags  <= '0;
        end else if (capture) begin
            result <= res_d;
            flags  <= flags_d;
        end
    end

    // the opcode comes from the register block, the strobe from control.
    a_op_known: assert property (@(posedge clk) disable iff (rst) capture |-> !$isunknown(op));

endmodule

`default_nettype wire

//--- rtl/fast_adder_16.sv
// 16-bit carry-lookahead adder block, cascaded through its group generate and propagate outputs.
`default_nettype none

module fast_adder_16 (
    input  wire  [15:0] a,
    input  wire  [15:0] b,
    input  wire         cin,
    output logic [15:0] s,
    output logic        cout,
    output logic        gout,
    output logic        pout
);

    logic [15:0] g;     // bit generate.
    logic [15:0] p;     // bit propagate.
    logic [15:0] grp_g; // generate of bits i..0.
    logic [15:0] grp_p; // propagate of bits i..0.
    logic [16:0] c;

    assign g = a & b;
    assign p = a | b;

    // each carry is a flat sum of products over the bits below it.
    for (genvar i = 0; i < 16; i++) begin : g_carry
        logic [i:0] term;

        for (genvar j = 0; j <= i; j++) begin : g_term
            if (j == i) begin : g_top
                assign term[j] = g[j];
            end else begin : g_span
                assign term[j] = g[j] & (&p[i:j+1]);
            end
        end

        assign grp_g[i] = |term;
        assign grp_p[i] = &p[i:0];
        assign c[i+1]   = grp_g[i] | (grp_p[i] & cin);
    end

    assign c[0] = cin;
    assign s    = a ^ b ^ c[15:0];
    assign cout = c[16];

    // group terms of the whole block for the next lookahead level.
    assign gout = grp_g[15];
    assign pout = grp_p[15];

endmodule

`default_nettype wire

//--- rtl/wb_map_pkg.sv
// Wishbone side definitions: register word addresses, control states and status bits.
`default_nettype none

package wb_map_pkg;

    // word addresses, taken from adr[3:2].
    localparam logic [1:0] REG_OP_A   = 2'd0;
    localparam logic [1:0] REG_OP_B   = 2'd1;
    localparam logic [1:0] REG_CMD    = 2'd2; // write starts an op, read gives status.
    localparam logic [1:0] REG_RESULT = 2'd3;

    typedef enum logic [1:0] {
        ST_IDLE = 2'd0,
        ST_EXEC = 2'd1,
        ST_DONE = 2'd2
    } ctrl_state_e;

    // status word holds the flags in bits 3..0.
    localparam int STAT_BUSY = 4;

endpackage

`default_nettype wire

//--- rtl/alu_pkg.sv
// ALU datapath definitions shared by the execution unit, the register block and the testbench.
`default_nettype none

package alu_pkg;

    // width of operands, result and bus data.
    localparam int DATA_W = 32;

    typedef enum logic [2:0] {
        OP_ADD = 3'd0,
        OP_SUB = 3'd1,
        OP_AND = 3'd2,
        OP_OR  = 3'd3,
        OP_XOR = 3'd4,
        OP_SLT = 3'd5, // signed compare.
        OP_SLL = 3'd6,
        OP_SRL = 3'd7
    } alu_op_e;

    // positions inside the 4-bit flags value.
    localparam int FLAG_Z = 0;
    localparam int FLAG_C = 1;
    localparam int FLAG_V = 2;
    localparam int FLAG_N = 3;

endpackage

`default_nettype wire
